// ==== include/videoUla_defines.svh ====
`ifndef VIDEOULA_DEFINES_SVH
`define VIDEOULA_DEFINES_SVH

// ******************************
// Bus widths
// ******************************

// CPU data bus and character byte
`define ULA_DATA_WIDTH 8

// 16 MHz divider with bits 0..3 giving 8/4/2/1 MHz
`define ULA_DIV_WIDTH 4

// ******************************
// Palette sizing
// ******************************

`define ULA_PAL_DEPTH 16 // One entry per logical colour
`define ULA_PAL_ADDR_WIDTH 4 // Index from interleaved shifter bits

`endif

// ==== verilog/videoUlaPkg.sv ====
package videoUlaPkg;

	// Pixel shift rate, control bits 3:2
	typedef enum logic [1:0] {
		rate2MHz = 2'd0,
		rate4MHz = 2'd1,
		rate8MHz = 2'd2,
		rate16MHz = 2'd3
	} pixelRateT;

	// CRTC character clock, control bit 4
	typedef enum logic {
		crtc1MHz = 1'b0,
		crtc2MHz = 1'b1
	} crtcRateT;

	// Register port select from a0
	typedef enum logic {
		regControl = 1'b0,
		regPalette = 1'b1
	} regSelT;

	// Physical colour, blue in the top bit
	typedef struct packed {
		logic blue;
		logic green;
		logic red;
	} rgbT;

	// Palette entry, flash enable above the colour
	typedef struct packed {
		logic flash;
		rgbT colour;
	} palEntryT;

endpackage

// ==== verilog/ulaTimingCtrl.sv ====
`timescale 1ns/1ns
`include "videoUla_defines.svh"

module ulaTimingCtrl (
	input logic clk16MHz,
	input logic rstN,
	input logic csN,
	input logic a0,
	input logic [`ULA_DATA_WIDTH-1:0] data,
	output logic clk8MHz,
	output logic clk4MHz,
	output logic clk2MHz,
	output logic clk1MHz,
	output logic clkCrtc,
	output logic crtcLoad,
	output logic shiftEn,
	output logic flashEn,
	output logic palWrite,
	output logic [`ULA_PAL_ADDR_WIDTH-1:0] palAddr,
	output videoUlaPkg::palEntryT palValue
);

	logic [`ULA_DIV_WIDTH-1:0] counter; // Master divider
	logic [`ULA_DATA_WIDTH-1:0] controlReg;
	videoUlaPkg::pixelRateT pixelRate;
	videoUlaPkg::crtcRateT crtcRate;
	videoUlaPkg::regSelT regSel;
	logic writeStrobe; // Last 16 MHz cycle of each 2 MHz period
	logic controlWrite;

	// ******************************
	// Clock divider
	// ******************************

	always_ff @(posedge clk16MHz or negedge rstN) begin
		if (!rstN) begin
			counter <= '0;
		end else begin
			counter <= counter + 1'b1; // Free running and wraps at 16
		end
	end

	assign clk8MHz = counter[0];
	assign clk4MHz = counter[1];
	assign clk2MHz = counter[2];
	assign clk1MHz = counter[3];

	// Control field decode
	assign pixelRate = videoUlaPkg::pixelRateT'(controlReg[3:2]);
	assign crtcRate = videoUlaPkg::crtcRateT'(controlReg[4]);
	assign flashEn = controlReg[0];

	assign clkCrtc = (crtcRate == videoUlaPkg::crtc2MHz) ? clk2MHz : clk1MHz;

	// One cycle ahead of the CRTC clock rising edge
	assign crtcLoad = (crtcRate == videoUlaPkg::crtc2MHz) ?
		(~counter[2] & (&counter[1:0])) :
		(~counter[3] & (&counter[2:0]));

	// ******************************
	// Pixel shift strobe
	// ******************************

	always_comb begin
		shiftEn = 1'b0;
		case (pixelRate)
			videoUlaPkg::rate2MHz: shiftEn = &counter[2:0];
			videoUlaPkg::rate4MHz: shiftEn = &counter[1:0];
			videoUlaPkg::rate8MHz: shiftEn = counter[0];
			videoUlaPkg::rate16MHz: shiftEn = 1'b1; // Every cycle
			default: shiftEn = 1'b0;
		endcase
	end

	// ******************************
	// Register port
	// ******************************

	assign writeStrobe = &counter[2:0];
	assign regSel = videoUlaPkg::regSelT'(a0);

	// High nibble picks the palette entry and low nibble is the value
	assign palWrite = writeStrobe & ~csN & (regSel == videoUlaPkg::regPalette);
	assign palAddr = data[`ULA_DATA_WIDTH-1 -: `ULA_PAL_ADDR_WIDTH];
	assign palValue = videoUlaPkg::palEntryT'(data[`ULA_PAL_ADDR_WIDTH-1:0]);

	assign controlWrite = writeStrobe & ~csN & (regSel == videoUlaPkg::regControl);

	always_ff @(posedge clk16MHz or negedge rstN) begin
		if (!rstN) begin
			controlReg <= '0; // 1 MHz CRTC, 2 MHz pixels, flash off
		end else if (controlWrite) begin
			controlReg <= data;
		end
	end

endmodule

// ==== verilog/pixelShifter.sv ====
`timescale 1ns/1ns
`include "videoUla_defines.svh"

module pixelShifter (
	input logic clk16MHz,
	input logic rstN,
	input logic crtcLoad,
	input logic shiftEn,
	input logic [`ULA_DATA_WIDTH-1:0] data,
	output logic [`ULA_PAL_ADDR_WIDTH-1:0] pixelIndex
);

	logic [`ULA_DATA_WIDTH-1:0] shiftReg; // Current character byte

	// ******************************
	// Load and shift
	// ******************************

	// Load wins over shift when both strobes coincide
	always_ff @(posedge clk16MHz or negedge rstN) begin
		if (!rstN) begin
			shiftReg <= '0;
		end else if (crtcLoad) begin
			shiftReg <= data; // New byte from display memory
		end else if (shiftEn) begin
			// Move left with ones filling from the bottom
			shiftReg <= {shiftReg[`ULA_DATA_WIDTH-2:0], 1'b1};
		end
	end

	// ******************************
	// Palette index
	// ******************************

	// Odd bits interleaved with MSB first
	assign pixelIndex = {
		shiftReg[7],
		shiftReg[5],
		shiftReg[3],
		shiftReg[1]
	};

endmodule

// ==== verilog/paletteColour.sv ====
`timescale 1ns/1ns
`include "videoUla_defines.svh"

module paletteColour (
	input logic clk16MHz,
	input logic rstN,
	input logic palWrite,
	input logic [`ULA_PAL_ADDR_WIDTH-1:0] palAddr,
	input videoUlaPkg::palEntryT palValue,
	input logic [`ULA_PAL_ADDR_WIDTH-1:0] pixelIndex,
	input logic flashEn,
	input logic disEn,
	output logic red,
	output logic green,
	output logic blue
);

	videoUlaPkg::palEntryT palMem [`ULA_PAL_DEPTH];
	videoUlaPkg::palEntryT palOut; // Entry for the current pixel
	videoUlaPkg::rgbT pixelColour;
	logic invertEn;

	// ******************************
	// Palette memory
	// ******************************

	always_ff @(posedge clk16MHz or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `ULA_PAL_DEPTH; i++) begin
				palMem[i] <= '0;
			end
		end else if (palWrite) begin
			palMem[palAddr] <= palValue; // Visible on the next cycle
		end
	end

	// ******************************
	// Lookup and output
	// ******************************

	assign palOut = palMem[pixelIndex];

	// Stored colours are active low
	// Flash phase with flash bit set shows them as stored
	assign invertEn = ~(flashEn & palOut.flash);

	always_comb begin
		if (invertEn) begin
			pixelColour = ~palOut.colour;
		end else begin
			pixelColour = palOut.colour;
		end
	end

	// Blank outside the active display area
	assign {blue, green, red} = disEn ? pixelColour : 3'b000;

endmodule

// ==== verilog/videoUla.sv ====
`timescale 1ns/1ns
`include "videoUla_defines.svh"

module videoUla (
	input logic clk16MHz,
	input logic rstN,
	input logic a0,
	input logic csN,
	input logic disEn,
	input logic cursor, // Not implemented
	input logic [`ULA_DATA_WIDTH-1:0] data,
	output logic clk8MHz,
	output logic clk4MHz,
	output logic clk2MHz,
	output logic clk1MHz,
	output logic clkCrtc,
	output logic red,
	output logic green,
	output logic blue
);

	// ******************************
	// Internal nets
	// ******************************

	logic crtcLoad; // Byte load one cycle before the CRTC edge
	logic shiftEn;
	logic flashEn;
	logic palWrite;
	logic [`ULA_PAL_ADDR_WIDTH-1:0] palAddr;
	videoUlaPkg::palEntryT palValue;
	logic [`ULA_PAL_ADDR_WIDTH-1:0] pixelIndex;

	// Divider, control register, strobes
	ulaTimingCtrl ulaTimingCtrl_i (
		.clk16MHz (clk16MHz),
		.rstN     (rstN),
		.csN      (csN),
		.a0       (a0),
		.data     (data),
		.clk8MHz  (clk8MHz),
		.clk4MHz  (clk4MHz),
		.clk2MHz  (clk2MHz),
		.clk1MHz  (clk1MHz),
		.clkCrtc  (clkCrtc),
		.crtcLoad (crtcLoad),
		.shiftEn  (shiftEn),
		.flashEn  (flashEn),
		.palWrite (palWrite),
		.palAddr  (palAddr),
		.palValue (palValue)
	);

	pixelShifter pixelShifter_i (
		.clk16MHz   (clk16MHz),
		.rstN       (rstN),
		.crtcLoad   (crtcLoad),
		.shiftEn    (shiftEn),
		.data       (data),
		.pixelIndex (pixelIndex)
	);

	// Palette lookup to RGB pins
	paletteColour paletteColour_i (
		.clk16MHz   (clk16MHz),
		.rstN       (rstN),
		.palWrite   (palWrite),
		.palAddr    (palAddr),
		.palValue   (palValue),
		.pixelIndex (pixelIndex),
		.flashEn    (flashEn),
		.disEn      (disEn),
		.red        (red),
		.green      (green),
		.blue       (blue)
	);

endmodule

// ==== verif/videoUlaTb.sv ====
`timescale 1ns/1ns
`include "videoUla_defines.svh"

module videoUlaTb;

	// Tests run for about 1,900 cycles
	localparam int TIMEOUT_CYCLES = 4000;

	logic clk16MHz;
	logic rstN;
	logic a0;
	logic csN;
	logic disEn;
	logic cursor; // Unused by the DUT
	logic [`ULA_DATA_WIDTH-1:0] data;
	logic clk8MHz;
	logic clk4MHz;
	logic clk2MHz;
	logic clk1MHz;
	logic clkCrtc;
	logic red;
	logic green;
	logic blue;

	// ******************************
	// Reference model state
	// ******************************

	logic [`ULA_DIV_WIDTH-1:0] modelCount; // Mirrors the divider
	logic [`ULA_DATA_WIDTH-1:0] modelControl;
	logic [`ULA_DATA_WIDTH-1:0] modelShift;
	videoUlaPkg::palEntryT modelPal [`ULA_PAL_DEPTH];
	logic modelLoad;
	logic modelShiftEn;
	logic modelWrite;
	int errorCount = 0;
	int cycleCount = 0;

	videoUla videoUla_i (
		.clk16MHz (clk16MHz),
		.rstN     (rstN),
		.a0       (a0),
		.csN      (csN),
		.disEn    (disEn),
		.cursor   (cursor),
		.data     (data),
		.clk8MHz  (clk8MHz),
		.clk4MHz  (clk4MHz),
		.clk2MHz  (clk2MHz),
		.clk1MHz  (clk1MHz),
		.clkCrtc  (clkCrtc),
		.red      (red),
		.green    (green),
		.blue     (blue)
	);

	initial begin
		clk16MHz = 1'b0;
		forever #5 clk16MHz = ~clk16MHz; // 10 ns period
	end

	// Model sees the same pre-edge inputs as the DUT
	always @(posedge clk16MHz) begin
		if (!rstN) begin
			modelCount = '0;
			modelControl = '0;
			modelShift = '0;
			for (int i = 0; i < `ULA_PAL_DEPTH; i++) begin
				modelPal[i] = '0;
			end
		end else begin
			// Load one cycle before the CRTC clock rises
			if (videoUlaPkg::crtcRateT'(modelControl[4]) == videoUlaPkg::crtc2MHz) begin
				modelLoad = (modelCount[1:0] == 2'b11) && !modelCount[2];
			end else begin
				modelLoad = (modelCount[2:0] == 3'b111) && !modelCount[3];
			end
			case (videoUlaPkg::pixelRateT'(modelControl[3:2]))
				videoUlaPkg::rate2MHz: modelShiftEn = (modelCount[2:0] == 3'b111);
				videoUlaPkg::rate4MHz: modelShiftEn = (modelCount[1:0] == 2'b11);
				videoUlaPkg::rate8MHz: modelShiftEn = modelCount[0];
				videoUlaPkg::rate16MHz: modelShiftEn = 1'b1;
				default: modelShiftEn = 1'b0;
			endcase
			modelWrite = (modelCount[2:0] == 3'b111) && !csN; // 2 MHz write strobe
			if (modelLoad) begin
				modelShift = data;
			end else if (modelShiftEn) begin
				modelShift = {modelShift[6:0], 1'b1}; // Ones fill from the bottom
			end
			if (modelWrite && videoUlaPkg::regSelT'(a0) == videoUlaPkg::regPalette) begin
				modelPal[data[7:4]] = videoUlaPkg::palEntryT'(data[3:0]);
			end else if (modelWrite) begin
				modelControl = data;
			end
			modelCount = modelCount + 1'b1;
		end
	end

	always @(posedge clk16MHz) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the tests did not complete", cycleCount);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// ******************************
	// Prediction and compare
	// ******************************

	function automatic videoUlaPkg::rgbT predictRgb();
		logic [3:0] index;
		videoUlaPkg::palEntryT entry;
		logic [2:0] raw;
		index = {modelShift[7], modelShift[5], modelShift[3], modelShift[1]};
		entry = modelPal[index];
		raw = entry.colour;
		if (!(modelControl[0] && entry.flash)) begin
			raw = ~raw; // Inverted unless flashing
		end
		if (!disEn) begin
			raw = 3'b000; // Blanked
		end
		return videoUlaPkg::rgbT'(raw);
	endfunction

	function automatic logic [4:0] predictClocks();
		logic crtc;
		crtc = modelControl[4] ? modelCount[2] : modelCount[3];
		return {crtc, modelCount[3], modelCount[2], modelCount[1], modelCount[0]};
	endfunction

	task automatic checkRgb(input string name, input videoUlaPkg::rgbT expected,
		input videoUlaPkg::rgbT actual);
		if (actual !== expected) begin
			errorCount++;
			$display("error: %s expected 0x%0h actual 0x%0h at %0t", name, expected, actual, $time);
		end
	endtask

	task automatic checkClocks(input string name, input logic [4:0] expected,
		input logic [4:0] actual);
		if (actual !== expected) begin
			errorCount++;
			$display("error: %s expected 0x%0h actual 0x%0h at %0t", name, expected, actual, $time);
		end
	endtask

	task automatic checkOutputs();
		checkRgb("rgb", predictRgb(), videoUlaPkg::rgbT'({blue, green, red}));
		checkClocks("clocks", predictClocks(), {clkCrtc, clk1MHz, clk2MHz, clk4MHz, clk8MHz});
	endtask

	// Every task ends just after a falling edge
	task automatic runCycles(input int n);
		repeat (n) begin
			@(posedge clk16MHz);
			@(negedge clk16MHz);
			checkOutputs();
		end
	endtask

	task automatic presentByte(input logic [`ULA_DATA_WIDTH-1:0] value);
		@(posedge clk16MHz);
		data <= value;
		@(negedge clk16MHz);
		checkOutputs();
	endtask

	// csN low for 8 cycles covers exactly one strobe
	task automatic writeRegister(input videoUlaPkg::regSelT sel,
		input logic [`ULA_DATA_WIDTH-1:0] value);
		@(posedge clk16MHz);
		csN <= 1'b0;
		a0 <= sel;
		data <= value;
		@(negedge clk16MHz);
		checkOutputs();
		runCycles(7);
		@(posedge clk16MHz);
		csN <= 1'b1;
		@(negedge clk16MHz);
		checkOutputs();
	endtask

	// ******************************
	// Directed tests
	// ******************************

	task automatic testReset();
		repeat (4) begin
			@(posedge clk16MHz);
			@(negedge clk16MHz);
			checkClocks("clocks in reset", 5'b00000, {clkCrtc, clk1MHz, clk2MHz, clk4MHz, clk8MHz});
			checkRgb("rgb in reset", 3'b000, videoUlaPkg::rgbT'({blue, green, red}));
		end
		@(posedge clk16MHz);
		rstN <= 1'b1;
		@(negedge clk16MHz);
		checkClocks("clocks after reset", 5'b00000, {clkCrtc, clk1MHz, clk2MHz, clk4MHz, clk8MHz});
		checkRgb("rgb after reset", 3'b000, videoUlaPkg::rgbT'({blue, green, red}));
		checkOutputs();
		runCycles(8);
	endtask

	task automatic testClockDivision();
		runCycles(64); // clkCrtc on 1 MHz
		writeRegister(videoUlaPkg::regControl, 8'h10);
		runCycles(64); // Now on 2 MHz
	endtask

	task automatic testPixelSequence();
		for (int i = 0; i < `ULA_PAL_DEPTH; i++) begin
			writeRegister(videoUlaPkg::regPalette, {4'(i), 4'($urandom)});
		end
		@(posedge clk16MHz);
		disEn <= 1'b1;
		@(negedge clk16MHz);
		checkOutputs();
		for (int rate = 0; rate < 4; rate++) begin
			writeRegister(videoUlaPkg::regControl, {4'b0000, 2'(rate), 2'b00});
			repeat (16) begin
				presentByte(8'($urandom));
				runCycles(15); // Rest of the 1 MHz load period
			end
		end
	endtask

	task automatic testFlash();
		writeRegister(videoUlaPkg::regControl, 8'h09); // Flash on, 8 MHz pixels
		for (int i = 0; i < `ULA_PAL_DEPTH; i++) begin
			// Even entries flash, odd ones do not
			writeRegister(videoUlaPkg::regPalette, {4'(i), ~i[0], 3'($urandom)});
		end
		repeat (8) begin
			presentByte(8'($urandom));
			runCycles(15);
		end
	endtask

	task automatic testBlanking();
		@(posedge clk16MHz);
		disEn <= 1'b0;
		@(negedge clk16MHz);
		checkOutputs();
		repeat (4) begin
			presentByte(8'($urandom));
			runCycles(15);
		end
		writeRegister(videoUlaPkg::regPalette, 8'($urandom)); // Palette changes while blank
		@(posedge clk16MHz);
		disEn <= 1'b1;
		@(negedge clk16MHz);
		checkOutputs(); // Colour back in the same cycle
		runCycles(16);
	endtask

	task automatic testWriteGating();
		logic nextStrobe;
		writeRegister(videoUlaPkg::regControl, 8'h04);
		// Chip select idle while the bus is busy
		repeat (48) begin
			@(posedge clk16MHz);
			a0 <= 1'($urandom);
			data <= 8'($urandom) | 8'h10; // Stray control write would move clkCrtc
			@(negedge clk16MHz);
			checkOutputs();
		end
		// Chip select low everywhere except the strobe cycle
		repeat (48) begin
			nextStrobe = (modelCount[2:0] == 3'b110);
			@(posedge clk16MHz);
			csN <= nextStrobe;
			a0 <= 1'($urandom);
			data <= 8'($urandom) | 8'h10;
			@(negedge clk16MHz);
			checkOutputs();
		end
		@(posedge clk16MHz);
		csN <= 1'b1;
		@(negedge clk16MHz);
		checkOutputs();
		runCycles(32);
	endtask

	// ******************************
	// Main sequence
	// ******************************

	initial begin
		rstN = 1'b0;
		csN = 1'b1;
		a0 = 1'b0;
		disEn = 1'b0; // Colours read zero in reset
		cursor = 1'b0;
		data = '0;
		void'($urandom(93495));
		testReset();
		testClockDivision();
		testPixelSequence();
		testFlash();
		testBlanking();
		testWriteGating();
		$display("Run complete with %0d errors", errorCount);
		if (errorCount == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+include
verilog/videoUlaPkg.sv
verilog/ulaTimingCtrl.sv
verilog/pixelShifter.sv
verilog/paletteColour.sv
verilog/videoUla.sv
verif/videoUlaTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f all.f --top-module videoUlaTb

simOut=$(./obj_dir/VvideoUlaTb)
printf '%s\n' "$simOut"

if printf '%s\n' "$simOut" | grep -q '^STATUS: PASS$'; then
	exit 0
fi
exit 1
